//--- design/vector_pkg.sv
package vector_pkg;

    // Half-precision value, IEEE 754 binary16 layout
    typedef struct packed {
        logic       sign;
        logic [4:0] exp;
        logic [9:0] mant;
    } fp16_t;

    // Reduction operations supported by the comparison tree
    typedef enum logic [1:0] {
        RED_MAX  = 2'd0,
        RED_MIN  = 2'd1,
        RED_AMAX = 2'd2
    } red_op_e;

    // Lane count of the reduction operand
    localparam int LANES = 16;

    // Destination vector length and its element index width
    localparam int NUM_ELEMENTS = 32;
    localparam int IMM_W = $clog2(NUM_ELEMENTS);

    // Tree depth, one registered level per halving
    localparam int LEVELS = $clog2(LANES);

    // Input register, tree levels and the output register of the merge
    localparam int PIPE_STAGES = LEVELS + 2;

    // How the reduced value lands in the destination vector
    typedef enum logic [1:0] {
        WR_INSERT    = 2'd0,
        WR_CLEAR     = 2'd1,
        WR_BROADCAST = 2'd2
    } wr_mode_e;

    // Full destination vector
    typedef fp16_t fp16_vec_t [NUM_ELEMENTS];

endpackage

//--- design/fp16_cmp_node.sv
`timescale 1ns/100ps

module fp16_cmp_node import vector_pkg::*; (
    input  fp16_t   a,
    input  fp16_t   b,
    input  red_op_e op,
    output fp16_t   y
);

    logic [15:0] key_a;
    logic [15:0] key_b;

    // Ordering key per operand
    // Positive values sit above all negatives, so -0 orders below +0
    // For max-magnitude the sign is ignored
    function automatic logic [15:0] order_key(input fp16_t v, input red_op_e kop);
        logic [14:0] mag;
        mag = {v.exp, v.mant};
        if (kop == RED_AMAX) begin
            order_key = {1'b0, mag};
        end else if (v.sign) begin
            order_key = {1'b0, ~mag};
        end else begin
            order_key = {1'b1, mag};
        end
    endfunction

    assign key_a = order_key(a, op);
    assign key_b = order_key(b, op);

    // Strict compares so that a tie keeps a, the lower lane
    always_comb begin
        case (op)
            RED_MAX, RED_AMAX: y = (key_b > key_a) ? b : a;
            RED_MIN:           y = (key_b < key_a) ? b : a;
            default:           y = a;
        endcase
    end

endmodule

//--- design/reduction_tree.sv
`timescale 1ns/100ps

module reduction_tree import vector_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    input  fp16_t   data_in [LANES],
    input  red_op_e op,
    input  logic    valid_in,
    output fp16_t   data_out
);

    // Heap-ordered node storage
    // Leaves sit at LANES..2*LANES-1, node j combines 2j and 2j+1, root is 1
    fp16_t   node_q [1:2*LANES-1];
    fp16_t   node_y [1:LANES-1];

    // Operation carried alongside each registered level
    red_op_e op_q [LEVELS];

    for (genvar j = 1; j < LANES; j++) begin : g_node
        // Depth of node j is floor(log2 j), root at depth 0
        localparam int DEPTH = $clog2(j + 1) - 1;
        // Register stage that captures this node's result
        localparam int STG = LEVELS - DEPTH;

        fp16_cmp_node u_node (
            .a  (node_q[2*j]),
            .b  (node_q[2*j+1]),
            .op (op_q[STG-1]),
            .y  (node_y[j])
        );
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 1; i < 2*LANES; i++) begin
                node_q[i] <= '0;
            end
            for (int s = 0; s < LEVELS; s++) begin
                op_q[s] <= RED_MAX;
            end
        end else begin
            // Input register
            for (int i = 0; i < LANES; i++) begin
                node_q[LANES+i] <= data_in[i];
            end
            op_q[0] <= op;

            // One register per tree level
            for (int j = 1; j < LANES; j++) begin
                node_q[j] <= node_y[j];
            end
            for (int s = 1; s < LEVELS; s++) begin
                op_q[s] <= op_q[s-1];
            end
        end
    end

    assign data_out = node_q[1];

    // A sampled operation must be one the nodes know how to perform
    a_legal_op: assert property (
        @(posedge CLK) disable iff (!nRST)
        valid_in |-> (op inside {RED_MAX, RED_MIN, RED_AMAX})
    ) else $error("reduction_tree: illegal reduction op %0d with valid_in", op);

endmodule

//--- design/param_sr.sv
`timescale 1ns/100ps

module param_sr #(
    parameter type T      = logic [15:0],
    parameter int  STAGES = 1
) (
    input  logic CLK,
    input  logic nRST,
    input  T     data_in,
    output T     data_out
);

    T sr_q [STAGES];

    // Depth of zero would leave the output undriven
    if (STAGES < 1) begin : g_bad_depth
        $error("param_sr: STAGES must be at least 1, got %0d", STAGES);
    end

    // Shifts every cycle, so the delay never depends on traffic
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < STAGES; i++) begin
                sr_q[i] <= '{default: '0};
            end
        end else begin
            sr_q[0] <= data_in;
            for (int i = 1; i < STAGES; i++) begin
                sr_q[i] <= sr_q[i-1];
            end
        end
    end

    assign data_out = sr_q[STAGES-1];

endmodule

//--- design/vreduction_ctrl.sv
`timescale 1ns/100ps

module vreduction_ctrl import vector_pkg::*; (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             input_valid,
    input  logic [IMM_W-1:0] imm,
    input  logic             broadcast,
    input  logic             clear,
    output logic             wr_valid,
    output wr_mode_e         wr_mode,
    output logic [IMM_W-1:0] wr_index
);

    // Side-band fields that ride next to the tree
    typedef struct packed {
        logic             valid;
        logic [IMM_W-1:0] imm;
        logic             broadcast;
        logic             clear;
    } sideband_t;

    sideband_t sb_in;
    sideband_t sb_out;

    always_comb begin
        sb_in.valid     = input_valid;
        sb_in.imm       = imm;
        sb_in.broadcast = broadcast;
        sb_in.clear     = clear;
    end

    // Same depth as the input register plus the tree levels
    param_sr #(
        .T      (sideband_t),
        .STAGES (PIPE_STAGES - 1)
    ) u_sb_sr (
        .CLK      (CLK),
        .nRST     (nRST),
        .data_in  (sb_in),
        .data_out (sb_out)
    );

    assign wr_valid = sb_out.valid;
    assign wr_index = sb_out.imm;

    // Broadcast wins over clear, clear over insert
    always_comb begin
        if (sb_out.broadcast) begin
            wr_mode = WR_BROADCAST;
        end else if (sb_out.clear) begin
            wr_mode = WR_CLEAR;
        end else begin
            wr_mode = WR_INSERT;
        end
    end

    // An unknown valid here would leak into every later output strobe
    a_valid_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        !$isunknown(wr_valid)
    ) else $error("vreduction_ctrl: wr_valid is unknown");

endmodule

//--- design/vreduction_merge.sv
`timescale 1ns/100ps

module vreduction_merge import vector_pkg::*; (
    input  logic             CLK,
    input  logic             nRST,
    input  fp16_t            result,
    input  fp16_vec_t        pass_vec,
    input  logic             wr_valid,
    input  wr_mode_e         wr_mode,
    input  logic [IMM_W-1:0] wr_index,
    output fp16_vec_t        vector_output,
    output logic             output_valid
);

    fp16_vec_t merged;

    // Element rule per write mode
    always_comb begin
        for (int i = 0; i < NUM_ELEMENTS; i++) begin
            case (wr_mode)
                WR_BROADCAST: merged[i] = result;
                WR_CLEAR:     merged[i] = (IMM_W'(i) == wr_index) ? result : '0;
                default:      merged[i] = (IMM_W'(i) == wr_index) ? result : pass_vec[i];
            endcase
        end
    end

    // Output register, one edge after the tree result
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_ELEMENTS; i++) begin
                vector_output[i] <= '0;
            end
            output_valid <= 1'b0;
        end else begin
            vector_output <= merged;
            output_valid  <= wr_valid;
        end
    end

    // A write request must carry a mode that the element rule knows
    a_mode_legal: assert property (
        @(posedge CLK) disable iff (!nRST)
        wr_valid |-> (wr_mode inside {WR_INSERT, WR_CLEAR, WR_BROADCAST})
    ) else $error("vreduction_merge: illegal write mode %0d with wr_valid", wr_mode);

endmodule

//--- design/vreduction.sv
`timescale 1ns/100ps

module vreduction import vector_pkg::*; (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             input_valid,
    input  red_op_e          reduction_type,
    input  fp16_t            lane_input [LANES],
    input  fp16_vec_t        vector_input,
    input  logic [IMM_W-1:0] imm,
    input  logic             broadcast,
    input  logic             clear,
    output fp16_vec_t        vector_output,
    output logic             output_valid
);

    fp16_t            tree_result;
    fp16_vec_t        vec_gated;
    fp16_vec_t        pass_vec;
    logic             wr_valid;
    wr_mode_e         wr_mode;
    logic [IMM_W-1:0] wr_index;

    reduction_tree u_tree (
        .CLK      (CLK),
        .nRST     (nRST),
        .data_in  (lane_input),
        .op       (reduction_type),
        .valid_in (input_valid),
        .data_out (tree_result)
    );

    // Idle cycles carry a zero vector down the passthrough
    always_comb begin
        for (int i = 0; i < NUM_ELEMENTS; i++) begin
            vec_gated[i] = input_valid ? vector_input[i] : '0;
        end
    end

    param_sr #(
        .T      (fp16_vec_t),
        .STAGES (PIPE_STAGES - 1)
    ) u_pass_sr (
        .CLK      (CLK),
        .nRST     (nRST),
        .data_in  (vec_gated),
        .data_out (pass_vec)
    );

    vreduction_ctrl u_ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .input_valid (input_valid),
        .imm         (imm),
        .broadcast   (broadcast),
        .clear       (clear),
        .wr_valid    (wr_valid),
        .wr_mode     (wr_mode),
        .wr_index    (wr_index)
    );

    vreduction_merge u_merge (
        .CLK           (CLK),
        .nRST          (nRST),
        .result        (tree_result),
        .pass_vec      (pass_vec),
        .wr_valid      (wr_valid),
        .wr_mode       (wr_mode),
        .wr_index      (wr_index),
        .vector_output (vector_output),
        .output_valid  (output_valid)
    );

endmodule

//--- tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Flat bit images of the lane operand and the destination vector
typedef logic [LANES*16-1:0]        lane_bits_t;
typedef logic [NUM_ELEMENTS*16-1:0] vec_bits_t;

// Galois LFSR state, shared by every random draw
logic [31:0] lfsr_state;

function automatic logic lfsr_step();
    logic out_bit;
    out_bit = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out_bit;
endfunction

// One LFSR step per bit, first bit taken lands in the MSB of the field
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_step()};
    end
    return v;
endfunction

// Small pool so that ties and signed zeros show up often
function automatic fp16_t pick_fp16();
    logic [2:0] sel;
    fp16_t      v;
    sel = 3'(take_bits(3));
    case (sel)
        3'd0:    v = 16'h0000;
        3'd1:    v = 16'h8000;
        3'd2:    v = 16'h3c00;
        3'd3:    v = 16'hbc00;
        3'd4:    v = 16'h4000;
        3'd5:    v = 16'hc000;
        3'd6:    v = 16'h7bff;
        default: v = 16'(take_bits(16));
    endcase
    return v;
endfunction

// Sign-magnitude order, -0 below +0
function automatic logic sm_greater(input fp16_t a, input fp16_t b);
    if (a.sign != b.sign) begin
        return b.sign;
    end
    if (a.sign) begin
        return {a.exp, a.mant} < {b.exp, b.mant};
    end
    return {a.exp, a.mant} > {b.exp, b.mant};
endfunction

// Linear scan, a strictly better candidate replaces the best so far
function automatic fp16_t reduce_model(input lane_bits_t lanes, input red_op_e op);
    fp16_t best;
    fp16_t cand;
    logic  take;
    best = lanes[15:0];
    for (int i = 1; i < LANES; i++) begin
        cand = lanes[i*16 +: 16];
        case (op)
            RED_MIN:  take = sm_greater(best, cand);
            RED_AMAX: take = {cand.exp, cand.mant} > {best.exp, best.mant};
            default:  take = sm_greater(cand, best);
        endcase
        if (take) begin
            best = cand;
        end
    end
    return best;
endfunction

// Broadcast over clear over insert
function automatic vec_bits_t merge_model(input fp16_t res, input logic bcast,
                                          input logic clr, input logic [IMM_W-1:0] idx,
                                          input vec_bits_t pass);
    vec_bits_t v;
    for (int i = 0; i < NUM_ELEMENTS; i++) begin
        if (bcast || i == int'(idx)) begin
            v[i*16 +: 16] = res;
        end else if (clr) begin
            v[i*16 +: 16] = 16'h0000;
        end else begin
            v[i*16 +: 16] = pass[i*16 +: 16];
        end
    end
    return v;
endfunction

`endif

//--- tests/tb_vreduction.sv
`timescale 1ns/100ps

module tb_vreduction import vector_pkg::*; ();

    // Sampling edge feeds the input register, each tree level and the merge add one edge
    localparam int LATENCY       = LEVELS + 1;
    localparam int NUM_OPS       = 600;
    localparam int DRAIN_TIMEOUT = 4 * LATENCY;

    logic             CLK;
    logic             nRST;
    logic             input_valid;
    red_op_e          reduction_type;
    fp16_t            lane_input [LANES];
    fp16_vec_t        vector_input;
    logic [IMM_W-1:0] imm;
    logic             broadcast;
    logic             clear;
    fp16_vec_t        vector_output;
    logic             output_valid;

    `include "tb_model.svh"

    // Expected results, each with the edge after which it must show
    int        due_q [$];
    vec_bits_t exp_q [$];
    fp16_vec_t exp_vec;
    int        edge_cnt;
    int        wait_cnt;

    vreduction u_dut (
        .CLK            (CLK),
        .nRST           (nRST),
        .input_valid    (input_valid),
        .reduction_type (reduction_type),
        .lane_input     (lane_input),
        .vector_input   (vector_input),
        .imm            (imm),
        .broadcast      (broadcast),
        .clear          (clear),
        .vector_output  (vector_output),
        .output_valid   (output_valid)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED output_valid: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_vector(input fp16_vec_t got, input fp16_vec_t exp);
        int bad;
        bad = -1;
        for (int i = 0; i < NUM_ELEMENTS && bad < 0; i++) begin
            if (got[i] !== exp[i]) begin
                bad = i;
            end
        end
        if (bad >= 0) begin
            abort_run($sformatf("FAILED vector_output[%0d]: got %h expected %h",
                                bad, got[bad], exp[bad]));
        end
    endtask

    // Idle cycles keep lanes and side-band at zero, so the output must stay all zero
    // Random passthrough data checks the gating of vector_input
    task automatic drive_idle();
        input_valid    = 1'b0;
        reduction_type = RED_MAX;
        imm            = '0;
        broadcast      = 1'b0;
        clear          = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            lane_input[i] = 16'h0000;
        end
        for (int i = 0; i < NUM_ELEMENTS; i++) begin
            vector_input[i] = 16'(take_bits(16));
        end
    endtask

    task automatic drive_op();
        lane_bits_t lanes;
        vec_bits_t  pass;
        logic [1:0] op_bits;
        red_op_e    op;
        fp16_t      res;
        op_bits = 2'(take_bits(2));
        // Encoding 3 is not an operation, fold it onto max-magnitude
        op = (op_bits == 2'd3) ? RED_AMAX : red_op_e'(op_bits);
        input_valid    = 1'b1;
        reduction_type = op;
        imm            = IMM_W'(take_bits(IMM_W));
        broadcast      = take_bits(1) != 0;
        clear          = take_bits(1) != 0;
        for (int i = 0; i < LANES; i++) begin
            lanes[i*16 +: 16] = pick_fp16();
            lane_input[i]     = lanes[i*16 +: 16];
        end
        for (int i = 0; i < NUM_ELEMENTS; i++) begin
            pass[i*16 +: 16] = pick_fp16();
            vector_input[i]  = pass[i*16 +: 16];
        end
        res = reduce_model(lanes, op);
        due_q.push_back(edge_cnt + 1 + LATENCY);
        exp_q.push_back(merge_model(res, broadcast, clear, imm, pass));
    endtask

    task automatic check_outputs();
        vec_bits_t bits;
        if (due_q.size() > 0 && due_q[0] == edge_cnt) begin
            bits = exp_q.pop_front();
            void'(due_q.pop_front());
            check_valid(output_valid, 1'b1);
        end else begin
            bits = '0;
            check_valid(output_valid, 1'b0);
        end
        for (int i = 0; i < NUM_ELEMENTS; i++) begin
            exp_vec[i] = bits[i*16 +: 16];
        end
        check_vector(vector_output, exp_vec);
    endtask

    // Outputs are settled 1 ns after the edge, new inputs go out at the same point
    task automatic run_cycle(input logic want_valid);
        @(posedge CLK);
        #1;
        edge_cnt++;
        check_outputs();
        if (want_valid) begin
            drive_op();
        end else begin
            drive_idle();
        end
    endtask

    initial begin
        lfsr_state = 32'h1d02;
        edge_cnt   = 0;
        wait_cnt   = 0;
        nRST       = 1'b0;
        drive_idle();
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;

        // Quiet stretch after reset
        for (int i = 0; i < 10; i++) begin
            run_cycle(1'b0);
        end
        // Back-to-back operations
        for (int i = 0; i < 20; i++) begin
            run_cycle(1'b1);
        end
        // Random traffic, roughly one idle cycle in four
        for (int i = 0; i < NUM_OPS; i++) begin
            run_cycle(take_bits(2) != 0);
        end

        while (due_q.size() > 0 && wait_cnt < DRAIN_TIMEOUT) begin
            run_cycle(1'b0);
            wait_cnt++;
        end
        if (due_q.size() > 0) begin
            abort_run("timeout: results still pending after the input stream ended");
        end else begin
            // No stray pulses once the pipeline is empty
            for (int i = 0; i < 2 * LATENCY; i++) begin
                run_cycle(1'b0);
            end
            $display("all tests passed");
            $finish;
        end
    end

endmodule

//--- flist.f
+incdir+tests
design/vector_pkg.sv
design/fp16_cmp_node.sv
design/reduction_tree.sv
design/param_sr.sv
design/vreduction_ctrl.sv
design/vreduction_merge.sv
design/vreduction.sv
tests/tb_vreduction.sv

//--- run.sh
#!/bin/sh
# Build and run the vreduction testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_vreduction -o sim_vreduction
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_vreduction 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
